/* rtl/rename_pkg.sv */
package rename_pkg;

    // group sizes
    localparam int RENAME_WIDTH = 2;
    localparam int COMMIT_WIDTH = 2;
    localparam int NUM_SRCS = 2;

    // register files
    localparam int NUM_LREG = 32;
    localparam int NUM_PREG = 64;

    // index widths
    localparam int LREG_W = $clog2(NUM_LREG);
    localparam int PREG_W = $clog2(NUM_PREG);

    // free count must hold NUM_PREG itself
    localparam int CNT_W = $clog2(NUM_PREG + 1);

    // logical register index, x0 to x31
    typedef logic [LREG_W-1:0] lreg_idx_t;

    // physical register index, p0 to p63
    typedef logic [PREG_W-1:0] preg_idx_t;

    // number of free physical registers
    typedef logic [CNT_W-1:0] free_cnt_t;

endpackage

/* rtl/rat_map.sv */
`timescale 1ns/10ps

module rat_map (
    input  logic                                clk,
    input  logic                                i_reset,

    // rename group
    input  logic                                i_rename_vld,
    input  logic [rename_pkg::RENAME_WIDTH-1:0] i_has_rd,
    input  rename_pkg::lreg_idx_t  i_lrd [rename_pkg::RENAME_WIDTH],
    input  rename_pkg::lreg_idx_t  i_lrs [rename_pkg::RENAME_WIDTH][rename_pkg::NUM_SRCS],
    input  rename_pkg::preg_idx_t  i_alloc_prd [rename_pkg::RENAME_WIDTH],
    output rename_pkg::preg_idx_t  o_prd [rename_pkg::RENAME_WIDTH],
    output rename_pkg::preg_idx_t  o_prev_prd [rename_pkg::RENAME_WIDTH],
    output rename_pkg::preg_idx_t  o_prs [rename_pkg::RENAME_WIDTH][rename_pkg::NUM_SRCS],

    // commit group
    input  logic [rename_pkg::COMMIT_WIDTH-1:0] i_commit_vld,
    input  rename_pkg::lreg_idx_t  i_commit_lrd [rename_pkg::COMMIT_WIDTH],
    input  rename_pkg::preg_idx_t  i_commit_prd [rename_pkg::COMMIT_WIDTH],
    input  logic                                i_squash_vld,

    // freed registers, two cycles after commit
    output logic [rename_pkg::COMMIT_WIDTH-1:0] o_dealloc_vld,
    output rename_pkg::preg_idx_t  o_dealloc_prd [rename_pkg::COMMIT_WIDTH]
);
    import rename_pkg::*;

    // current renaming and renaming as of last commit
    preg_idx_t spec_map [NUM_LREG];
    preg_idx_t arch_map [NUM_LREG];

    // old arch mapping of each committing lrd
    preg_idx_t commit_prev [COMMIT_WIDTH];

    // first dealloc stage
    logic [COMMIT_WIDTH-1:0] dealloc_s1_vld;
    preg_idx_t dealloc_s1_prd [COMMIT_WIDTH];

    // rename lookup with intra-group bypass
    always_comb begin
        for (int a = 0; a < RENAME_WIDTH; a++) begin
            o_prd[a] = i_has_rd[a] ? i_alloc_prd[a] : '0;
            o_prev_prd[a] = spec_map[i_lrd[a]];
            for (int s = 0; s < NUM_SRCS; s++) begin
                o_prs[a][s] = spec_map[i_lrs[a][s]];
            end

            // older slots scanned oldest first, so the nearest writer wins
            for (int k = 0; k < a; k++) begin
                if (i_has_rd[k]) begin
                    if (i_lrd[k] == i_lrd[a]) begin
                        o_prev_prd[a] = i_alloc_prd[k];
                    end
                    for (int s = 0; s < NUM_SRCS; s++) begin
                        if (i_lrd[k] == i_lrs[a][s]) begin
                            o_prs[a][s] = i_alloc_prd[k];
                        end
                    end
                end
            end
        end
    end

    // speculative map
    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int r = 0; r < NUM_LREG; r++) begin
                spec_map[r] <= preg_idx_t'(r);
            end
        end else if (i_squash_vld) begin
            // roll back to committed state
            spec_map <= arch_map;
        end else if (i_rename_vld) begin
            // later slot overwrites an earlier one with the same lrd
            for (int a = 0; a < RENAME_WIDTH; a++) begin
                if (i_has_rd[a]) begin
                    spec_map[i_lrd[a]] <= i_alloc_prd[a];
                end
            end
        end
    end

    // architectural map
    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int r = 0; r < NUM_LREG; r++) begin
                arch_map[r] <= preg_idx_t'(r);
            end
        end else begin
            for (int c = 0; c < COMMIT_WIDTH; c++) begin
                if (i_commit_vld[c]) begin
                    arch_map[i_commit_lrd[c]] <= i_commit_prd[c];
                end
            end
        end
    end

    // previous mapping of each committing lrd
    always_comb begin
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            commit_prev[c] = arch_map[i_commit_lrd[c]];
            // same lrd committed earlier in this group frees that prd instead
            for (int b = 0; b < c; b++) begin
                if (i_commit_vld[b] && (i_commit_lrd[b] == i_commit_lrd[c])) begin
                    commit_prev[c] = i_commit_prd[b];
                end
            end
        end
    end

    // dealloc valid bits, two stages
    always_ff @(posedge clk) begin
        if (i_reset) begin
            dealloc_s1_vld <= '0;
            o_dealloc_vld <= '0;
        end else begin
            dealloc_s1_vld <= i_commit_vld;
            o_dealloc_vld <= dealloc_s1_vld;
        end
    end

    // dealloc payload
    always_ff @(posedge clk) begin
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            dealloc_s1_prd[c] <= commit_prev[c];
            o_dealloc_prd[c] <= dealloc_s1_prd[c];
        end
    end

endmodule

/* rtl/free_list.sv */
`timescale 1ns/10ps

module free_list (
    input  logic                                clk,
    input  logic                                i_reset,

    // allocation
    input  logic                                i_rename_vld,
    input  logic [rename_pkg::RENAME_WIDTH-1:0] i_has_rd,
    output rename_pkg::preg_idx_t  o_alloc_prd [rename_pkg::RENAME_WIDTH],

    // commit and squash move the heads
    input  logic [rename_pkg::COMMIT_WIDTH-1:0] i_commit_vld,
    input  logic                                i_squash_vld,

    // returned registers
    input  logic [rename_pkg::COMMIT_WIDTH-1:0] i_dealloc_vld,
    input  rename_pkg::preg_idx_t  i_dealloc_prd [rename_pkg::COMMIT_WIDTH],

    output rename_pkg::free_cnt_t               o_free_cnt
);
    import rename_pkg::*;

    // extra wrap bit tells full from empty
    typedef logic [PREG_W:0] ptr_t;

    preg_idx_t ring [NUM_PREG];

    ptr_t tail;
    ptr_t spec_head;
    ptr_t commit_head;

    ptr_t tail_nxt;
    ptr_t spec_head_nxt;
    ptr_t commit_head_nxt;

    // walking pointers for compaction
    ptr_t rd_ptr;
    ptr_t wr_ptr;
    preg_idx_t wr_idx [COMMIT_WIDTH];

    // slot without rd does not consume an entry
    always_comb begin
        rd_ptr = spec_head;
        for (int a = 0; a < RENAME_WIDTH; a++) begin
            o_alloc_prd[a] = ring[rd_ptr[PREG_W-1:0]];
            if (i_has_rd[a]) begin
                rd_ptr = rd_ptr + ptr_t'(1);
            end
        end
    end

    // valid deallocs fill consecutive tail slots
    always_comb begin
        wr_ptr = tail;
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            wr_idx[c] = wr_ptr[PREG_W-1:0];
            if (i_dealloc_vld[c]) begin
                wr_ptr = wr_ptr + ptr_t'(1);
            end
        end
    end

    always_comb begin
        tail_nxt = wr_ptr;
        commit_head_nxt = commit_head;
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            if (i_commit_vld[c]) begin
                commit_head_nxt = commit_head_nxt + ptr_t'(1);
            end
        end

        if (i_squash_vld) begin
            spec_head_nxt = commit_head;
        end else if (i_rename_vld) begin
            spec_head_nxt = rd_ptr;
        end else begin
            spec_head_nxt = spec_head;
        end
    end

    // pointers and free count
    always_ff @(posedge clk) begin
        if (i_reset) begin
            tail <= ptr_t'(NUM_LREG);
            spec_head <= '0;
            commit_head <= '0;
            o_free_cnt <= free_cnt_t'(NUM_LREG);
        end else begin
            tail <= tail_nxt;
            spec_head <= spec_head_nxt;
            commit_head <= commit_head_nxt;
            o_free_cnt <= tail_nxt - spec_head_nxt;
        end
    end

    // ring starts with p32..p63
    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int r = 0; r < NUM_PREG - NUM_LREG; r++) begin
                ring[r] <= preg_idx_t'(r + NUM_LREG);
            end
        end else begin
            for (int c = 0; c < COMMIT_WIDTH; c++) begin
                if (i_dealloc_vld[c]) begin
                    ring[wr_idx[c]] <= i_dealloc_prd[c];
                end
            end
        end
    end

endmodule

/* rtl/rename_stage.sv */
`timescale 1ns/10ps

module rename_stage (
    input  logic                                clk,
    input  logic                                i_reset,

    // rename group
    input  logic                                i_rename_vld,
    input  logic [rename_pkg::RENAME_WIDTH-1:0] i_has_rd,
    input  rename_pkg::lreg_idx_t  i_lrd [rename_pkg::RENAME_WIDTH],
    input  rename_pkg::lreg_idx_t  i_lrs [rename_pkg::RENAME_WIDTH][rename_pkg::NUM_SRCS],
    output rename_pkg::preg_idx_t  o_prd [rename_pkg::RENAME_WIDTH],
    output rename_pkg::preg_idx_t  o_prev_prd [rename_pkg::RENAME_WIDTH],
    output rename_pkg::preg_idx_t  o_prs [rename_pkg::RENAME_WIDTH][rename_pkg::NUM_SRCS],

    // commit group
    input  logic [rename_pkg::COMMIT_WIDTH-1:0] i_commit_vld,
    input  rename_pkg::lreg_idx_t  i_commit_lrd [rename_pkg::COMMIT_WIDTH],
    input  rename_pkg::preg_idx_t  i_commit_prd [rename_pkg::COMMIT_WIDTH],

    input  logic                                i_squash_vld,

    // freed registers and free count
    output logic [rename_pkg::COMMIT_WIDTH-1:0] o_dealloc_vld,
    output rename_pkg::preg_idx_t  o_dealloc_prd [rename_pkg::COMMIT_WIDTH],
    output rename_pkg::free_cnt_t               o_free_cnt
);
    import rename_pkg::*;

    // candidate destinations from the free list head
    preg_idx_t alloc_prd [RENAME_WIDTH];

    rat_map u_rat (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_rename_vld  (i_rename_vld),
        .i_has_rd      (i_has_rd),
        .i_lrd         (i_lrd),
        .i_lrs         (i_lrs),
        .i_alloc_prd   (alloc_prd),
        .o_prd         (o_prd),
        .o_prev_prd    (o_prev_prd),
        .o_prs         (o_prs),
        .i_commit_vld  (i_commit_vld),
        .i_commit_lrd  (i_commit_lrd),
        .i_commit_prd  (i_commit_prd),
        .i_squash_vld  (i_squash_vld),
        .o_dealloc_vld (o_dealloc_vld),
        .o_dealloc_prd (o_dealloc_prd)
    );

    // dealloc outputs loop back into the tail
    free_list u_free (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_rename_vld  (i_rename_vld),
        .i_has_rd      (i_has_rd),
        .o_alloc_prd   (alloc_prd),
        .i_commit_vld  (i_commit_vld),
        .i_squash_vld  (i_squash_vld),
        .i_dealloc_vld (o_dealloc_vld),
        .i_dealloc_prd (o_dealloc_prd),
        .o_free_cnt    (o_free_cnt)
    );

endmodule

/* test/rename_properties.sv */
`timescale 1ns/10ps

module rename_properties (
    input logic                                clk,
    input logic                                i_reset,
    input logic                                i_rename_vld,
    input logic [rename_pkg::RENAME_WIDTH-1:0] i_has_rd,
    input rename_pkg::lreg_idx_t               i_lrd [rename_pkg::RENAME_WIDTH],
    input logic [rename_pkg::COMMIT_WIDTH-1:0] i_commit_vld,
    input logic                                i_squash_vld,
    input logic [rename_pkg::COMMIT_WIDTH-1:0] o_dealloc_vld,
    input rename_pkg::free_cnt_t               o_free_cnt
);
    import rename_pkg::*;

    // x0 is hardwired to p0
    no_x0_rd: assert property (@(posedge clk) disable iff (i_reset)
        i_rename_vld |-> !(i_has_rd[0] && i_lrd[0] == '0) && !(i_has_rd[1] && i_lrd[1] == '0))
        else $error("rename writes x0");

    rename_needs_two_free: assert property (@(posedge clk) disable iff (i_reset)
        i_rename_vld |-> o_free_cnt >= free_cnt_t'(2))
        else $error("rename with fewer than two free registers");

    squash_alone: assert property (@(posedge clk) disable iff (i_reset)
        i_squash_vld |-> !i_rename_vld && i_commit_vld == '0)
        else $error("rename or commit in a squash cycle");

    // first stage must also come out of reset empty
    dealloc_idle_after_reset: assert property (@(posedge clk)
        $fell(i_reset) |=> o_dealloc_vld == '0)
        else $error("dealloc valid right after reset");

endmodule

bind rename_stage rename_properties u_props (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_rename_vld  (i_rename_vld),
    .i_has_rd      (i_has_rd),
    .i_lrd         (i_lrd),
    .i_commit_vld  (i_commit_vld),
    .i_squash_vld  (i_squash_vld),
    .o_dealloc_vld (o_dealloc_vld),
    .o_free_cnt    (o_free_cnt)
);

/* test/rename_tb.sv */
`timescale 1ns/10ps

module rename_tb;
    import rename_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 8;
    localparam int DEALLOC_TIMEOUT = 10;
    localparam int RANDOM_CYCLES = 2000;

    logic clk = 1'b0;
    logic i_reset;
    logic i_rename_vld;
    logic [RENAME_WIDTH-1:0] i_has_rd;
    lreg_idx_t i_lrd [RENAME_WIDTH];
    lreg_idx_t i_lrs [RENAME_WIDTH][NUM_SRCS];
    preg_idx_t o_prd [RENAME_WIDTH];
    preg_idx_t o_prev_prd [RENAME_WIDTH];
    preg_idx_t o_prs [RENAME_WIDTH][NUM_SRCS];
    logic [COMMIT_WIDTH-1:0] i_commit_vld;
    lreg_idx_t i_commit_lrd [COMMIT_WIDTH];
    preg_idx_t i_commit_prd [COMMIT_WIDTH];
    logic i_squash_vld;
    logic [COMMIT_WIDTH-1:0] o_dealloc_vld;
    preg_idx_t o_dealloc_prd [COMMIT_WIDTH];
    free_cnt_t o_free_cnt;

    integer seed = 79581;
    int value_errs = 0;
    int other_errs = 0;
    int cyc = 0;

    // model state
    preg_idx_t m_spec [NUM_LREG];
    preg_idx_t m_arch [NUM_LREG];
    preg_idx_t m_ring [NUM_PREG];
    logic [PREG_W:0] m_tail;
    logic [PREG_W:0] m_spec_head;
    logic [PREG_W:0] m_commit_head;
    free_cnt_t m_cnt;
    lreg_idx_t pend_lrd [$];
    preg_idx_t pend_prd [$];

    // expected deallocs, indexed by due cycle mod 4
    bit exp_dvld [4][COMMIT_WIDTH];
    preg_idx_t exp_dprd [4][COMMIT_WIDTH];

    // stimulus of the current cycle, seen by the model
    bit [1:0] s_has_rd;
    lreg_idx_t s_lrd [RENAME_WIDTH];
    lreg_idx_t s_lrs [RENAME_WIDTH][NUM_SRCS];

    rename_stage u_dut (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_rename_vld  (i_rename_vld),
        .i_has_rd      (i_has_rd),
        .i_lrd         (i_lrd),
        .i_lrs         (i_lrs),
        .o_prd         (o_prd),
        .o_prev_prd    (o_prev_prd),
        .o_prs         (o_prs),
        .i_commit_vld  (i_commit_vld),
        .i_commit_lrd  (i_commit_lrd),
        .i_commit_prd  (i_commit_prd),
        .i_squash_vld  (i_squash_vld),
        .o_dealloc_vld (o_dealloc_vld),
        .o_dealloc_prd (o_dealloc_prd),
        .o_free_cnt    (o_free_cnt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_preg(input string name, input preg_idx_t exp, input preg_idx_t act);
        if (exp !== act) begin
            value_errs++;
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_cnt(input string name, input free_cnt_t exp, input free_cnt_t act);
        if (exp !== act) begin
            value_errs++;
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_vld(input string name, input bit exp, input bit act);
        if (exp !== act) begin
            value_errs++;
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // kind 0 is prd, 1 is prev_prd, 2 is prs of source src
    function automatic preg_idx_t rename_ref(input int slot, input int kind, input int src);
        logic [PREG_W:0] ptr;
        lreg_idx_t lr;
        preg_idx_t val;
        preg_idx_t new_prd [RENAME_WIDTH];
        ptr = m_spec_head;
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            new_prd[k] = s_has_rd[k] ? m_ring[ptr[PREG_W-1:0]] : '0;
            if (s_has_rd[k]) begin
                ptr = ptr + 1'b1;
            end
        end
        if (kind == 0) begin
            return new_prd[slot];
        end
        lr = (kind == 1) ? s_lrd[slot] : s_lrs[slot][src];
        val = m_spec[lr];
        for (int k = 0; k < slot; k++) begin
            if (s_has_rd[k] && s_lrd[k] == lr) begin
                val = new_prd[k];
            end
        end
        return val;
    endfunction

    task automatic model_reset();
        for (int r = 0; r < NUM_LREG; r++) begin
            m_spec[r] = preg_idx_t'(r);
            m_arch[r] = preg_idx_t'(r);
        end
        for (int r = 0; r < NUM_PREG; r++) begin
            m_ring[r] = (r < NUM_PREG - NUM_LREG) ? preg_idx_t'(r + NUM_LREG) : '0;
        end
        m_tail = (PREG_W + 1)'(NUM_LREG);
        m_spec_head = '0;
        m_commit_head = '0;
        m_cnt = free_cnt_t'(NUM_LREG);
        for (int d = 0; d < 4; d++) begin
            for (int c = 0; c < COMMIT_WIDTH; c++) begin
                exp_dvld[d][c] = 1'b0;
                exp_dprd[d][c] = '0;
            end
        end
    endtask

    // drive one cycle, compare outputs, then advance the model past the edge
    task automatic cycle_step(input string name, input bit rvld, input bit [1:0] has_rd,
                              input lreg_idx_t lrd0, input lreg_idx_t lrd1,
                              input lreg_idx_t lrs00, input lreg_idx_t lrs01,
                              input lreg_idx_t lrs10, input lreg_idx_t lrs11,
                              input int ncommit, input bit squash);
        int ncm;
        int cur;
        preg_idx_t new_prd [RENAME_WIDTH];
        lreg_idx_t clrd;
        ncm = (ncommit > pend_lrd.size()) ? pend_lrd.size() : ncommit;
        cur = cyc % 4;
        s_has_rd = has_rd;
        s_lrd[0] = lrd0;
        s_lrd[1] = lrd1;
        s_lrs[0][0] = lrs00;
        s_lrs[0][1] = lrs01;
        s_lrs[1][0] = lrs10;
        s_lrs[1][1] = lrs11;

        @(posedge clk);
        i_rename_vld <= rvld;
        i_has_rd <= has_rd;
        i_squash_vld <= squash;
        for (int a = 0; a < RENAME_WIDTH; a++) begin
            i_lrd[a] <= s_lrd[a];
            for (int s = 0; s < NUM_SRCS; s++) begin
                i_lrs[a][s] <= s_lrs[a][s];
            end
        end
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            i_commit_vld[c] <= (c < ncm);
            i_commit_lrd[c] <= (c < ncm) ? pend_lrd[c] : '0;
            i_commit_prd[c] <= (c < ncm) ? pend_prd[c] : '0;
        end
        #1;

        check_cnt($sformatf("%s.free_cnt", name), m_cnt, o_free_cnt);
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            check_vld($sformatf("%s.dealloc_vld%0d", name, c), exp_dvld[cur][c],
                      o_dealloc_vld[c]);
            if (exp_dvld[cur][c]) begin
                check_preg($sformatf("%s.dealloc_prd%0d", name, c), exp_dprd[cur][c],
                           o_dealloc_prd[c]);
            end
        end
        if (rvld) begin
            for (int a = 0; a < RENAME_WIDTH; a++) begin
                check_preg($sformatf("%s.prd%0d", name, a), rename_ref(a, 0, 0), o_prd[a]);
                check_preg($sformatf("%s.prev_prd%0d", name, a), rename_ref(a, 1, 0),
                           o_prev_prd[a]);
                for (int s = 0; s < NUM_SRCS; s++) begin
                    check_preg($sformatf("%s.prs%0d_%0d", name, a, s), rename_ref(a, 2, s),
                               o_prs[a][s]);
                end
            end
        end

        for (int a = 0; a < RENAME_WIDTH; a++) begin
            new_prd[a] = rename_ref(a, 0, 0);
        end
        if (squash) begin
            m_spec = m_arch;
            m_spec_head = m_commit_head;
            pend_lrd.delete();
            pend_prd.delete();
        end else if (rvld) begin
            for (int a = 0; a < RENAME_WIDTH; a++) begin
                if (has_rd[a]) begin
                    m_spec[s_lrd[a]] = new_prd[a];
                    pend_lrd.push_back(s_lrd[a]);
                    pend_prd.push_back(new_prd[a]);
                    m_spec_head = m_spec_head + 1'b1;
                end
            end
        end
        // sequential update gives the same-group bypass for a repeated lrd
        for (int c = 0; c < ncm; c++) begin
            clrd = pend_lrd.pop_front();
            exp_dvld[(cyc + 2) % 4][c] = 1'b1;
            exp_dprd[(cyc + 2) % 4][c] = m_arch[clrd];
            m_arch[clrd] = pend_prd.pop_front();
            m_commit_head = m_commit_head + 1'b1;
        end
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            if (exp_dvld[cur][c]) begin
                m_ring[m_tail[PREG_W-1:0]] = exp_dprd[cur][c];
                m_tail = m_tail + 1'b1;
            end
            exp_dvld[cur][c] = 1'b0;
        end
        m_cnt = m_tail - m_spec_head;
        cyc++;
    endtask

    task automatic idle_step(input string name);
        cycle_step(name, 1'b0, 2'b00, '0, '0, '0, '0, '0, '0, 0, 1'b0);
    endtask

    task automatic wait_dealloc(input string name);
        int n = 0;
        while (o_dealloc_vld == '0 && n < DEALLOC_TIMEOUT) begin
            idle_step(name);
            n++;
        end
        if (o_dealloc_vld == '0) begin
            other_errs++;
            $display("Timeout in %s: no dealloc appeared after the commit", name);
        end
    endtask

    task automatic random_cycles();
        int rnd;
        bit rvld;
        bit sq;
        int ncm;
        lreg_idx_t lrd0;
        lreg_idx_t lrd1;
        lreg_idx_t lrs [4];
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            rnd = $random(seed);
            sq = (rnd[5:0] == 6'd0);
            rvld = !sq && (m_cnt >= 2) && (rnd[7:6] != 2'b00);
            ncm = sq ? 0 : ((rnd[9:8] == 2'b11) ? 2 : int'(rnd[9:8]));
            lrd0 = lreg_idx_t'($random(seed));
            lrd1 = lreg_idx_t'($random(seed));
            if (lrd0 == '0) lrd0 = lreg_idx_t'(1);
            if (lrd1 == '0) lrd1 = lreg_idx_t'(31);
            for (int s = 0; s < 4; s++) begin
                lrs[s] = lreg_idx_t'($random(seed));
            end
            // bias slot 1 toward reading slot 0's destination
            if (rnd[11:10] == 2'b00) lrs[2] = lrd0;
            if (rnd[13:12] == 2'b00) lrd1 = lrd0;
            cycle_step("random", rvld, rnd[15:14], lrd0, lrd1, lrs[0], lrs[1], lrs[2], lrs[3],
                       ncm, sq);
        end
    endtask

    initial begin
        i_reset = 1'b1;
        i_rename_vld = 1'b0;
        i_has_rd = '0;
        i_commit_vld = '0;
        i_squash_vld = 1'b0;
        for (int a = 0; a < RENAME_WIDTH; a++) begin
            i_lrd[a] = '0;
            i_lrs[a][0] = '0;
            i_lrs[a][1] = '0;
        end
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            i_commit_lrd[c] = '0;
            i_commit_prd[c] = '0;
        end
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        i_reset <= 1'b0;

        // mapping straight after reset
        cycle_step("reset_map", 1'b1, 2'b11, 5'd5, 5'd6, 5'd0, 5'd5, 5'd0, 5'd31, 0, 1'b0);
        check_preg("reset_map.first_prd0", 6'd32, o_prd[0]);
        check_preg("reset_map.first_prd1", 6'd33, o_prd[1]);
        check_preg("reset_map.x0", 6'd0, o_prs[0][0]);
        check_preg("reset_map.x31", 6'd31, o_prs[1][1]);
        check_cnt("reset_map.cnt", 7'd32, o_free_cnt);

        // same-group and next-group bypass
        cycle_step("bypass", 1'b1, 2'b11, 5'd7, 5'd7, 5'd5, 5'd1, 5'd7, 5'd6, 0, 1'b0);
        check_preg("bypass.src", 6'd34, o_prs[1][0]);
        check_preg("bypass.prev", 6'd34, o_prev_prd[1]);
        check_preg("bypass.spec_map", 6'd32, o_prs[0][0]);

        // slot 0 without a destination
        cycle_step("head_skip", 1'b1, 2'b10, 5'd0, 5'd9, 5'd7, 5'd2, 5'd3, 5'd4, 0, 1'b0);
        check_preg("head_skip.spec_map", 6'd35, o_prs[0][0]);
        check_preg("head_skip.prd1", 6'd36, o_prd[1]);
        check_preg("head_skip.prd0", 6'd0, o_prd[0]);
        idle_step("cnt_drop");
        check_cnt("cnt_drop.cnt", 7'd27, o_free_cnt);

        // commit frees the old mappings
        cycle_step("commit1", 1'b0, 2'b00, '0, '0, '0, '0, '0, '0, 2, 1'b0);
        wait_dealloc("commit1_free");
        check_preg("commit1.free0", 6'd5, o_dealloc_prd[0]);
        check_preg("commit1.free1", 6'd6, o_dealloc_prd[1]);
        cycle_step("commit2", 1'b0, 2'b00, '0, '0, '0, '0, '0, '0, 2, 1'b0);
        wait_dealloc("commit2_free");
        check_preg("commit2.free0", 6'd7, o_dealloc_prd[0]);
        check_preg("commit2.free1", 6'd34, o_dealloc_prd[1]);
        cycle_step("realloc", 1'b1, 2'b11, 5'd10, 5'd11, 5'd7, 5'd9, 5'd10, 5'd5, 0, 1'b0);

        // squash back to the committed state
        cycle_step("pre_squash", 1'b1, 2'b01, 5'd12, 5'd0, 5'd1, 5'd2, 5'd0, 5'd0, 0, 1'b0);
        cycle_step("squash", 1'b0, 2'b00, '0, '0, '0, '0, '0, '0, 0, 1'b1);
        cycle_step("post_squash", 1'b1, 2'b11, 5'd13, 5'd14, 5'd12, 5'd7, 5'd9, 5'd13,
                   0, 1'b0);
        check_preg("post_squash.arch12", 6'd12, o_prs[0][0]);
        check_preg("post_squash.arch7", 6'd35, o_prs[0][1]);
        check_preg("post_squash.commit_head", 6'd36, o_prd[0]);

        random_cycles();
        repeat (4) idle_step("drain");

        $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
rtl/rename_pkg.sv
rtl/rat_map.sv
rtl/free_list.sv
rtl/rename_stage.sv
test/rename_properties.sv
test/rename_tb.sv

/* run.sh */
#!/bin/bash
# build and run the rename testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module rename_tb \
    -f verilog.f \
    -o rename_sim

./obj_dir/rename_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification passed" sim.log; then
    exit 0
fi
exit 1
